/* Bender.yml */
package:
  name: spi_vga

sources:
  - verilog/spi_vga_pkg.sv
  - verilog/frame_ram.sv
  - verilog/spi_byte_receiver.sv
  - verilog/pixel_writer.sv
  - verilog/frame_buffer.sv
  - verilog/vga_timing.sv
  - verilog/spi_vga_top.sv
  - target: test
    files:
      - test/tb_spi_vga.sv

/* flist.f */
verilog/spi_vga_pkg.sv
verilog/frame_ram.sv
verilog/spi_byte_receiver.sv
verilog/pixel_writer.sv
verilog/frame_buffer.sv
verilog/vga_timing.sv
verilog/spi_vga_top.sv
test/tb_spi_vga.sv

/* test/tb_spi_vga.sv */
module tb_spi_vga
    import spi_vga_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Screen timing in clk cycles with two clk per pixel
    localparam int LINE_CLKS     = 1600;
    localparam int FRAME_CLKS    = 840000;
    localparam int CHECK_CLKS    = 1600 * 37;
    localparam int VSYNC_TIMEOUT = 850000;

    // Step kinds of the stimulus table
    localparam int K_SEND  = 0;
    localparam int K_CUT   = 1;
    localparam int K_FULL  = 2;
    localparam int K_CHECK = 3;

    logic   clk;
    logic   rst;
    logic   sclk;
    logic   cs_n;
    logic   mosi;
    color_t vga_r;
    color_t vga_g;
    color_t vga_b;
    logic   h_sync;
    logic   v_sync;

    int         errors;
    int         checks;
    bit         timed_out;
    logic [31:0] rng;
    int         kind_q[$];
    logic [7:0] data_q[$];
    logic [7:0] rand_pix [0:72];
    logic [7:0] exp_set [0:3][0:31];

    spi_vga_top UUT (
        .clk    (clk),
        .rst    (rst),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .vga_r  (vga_r),
        .vga_g  (vga_g),
        .vga_b  (vga_b),
        .h_sync (h_sync),
        .v_sync (v_sync)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 2-bit channel moved to the top of the 4-bit output
    function automatic logic [3:0] widen_channel(input logic [1:0] bits);
        return {bits, 2'b00};
    endfunction

    task automatic add_step(input int kind, input logic [7:0] data);
        kind_q.push_back(kind);
        data_q.push_back(data);
    endtask

    task automatic build_table();
        int i;
        rng = 32'd30;
        for (i = 0; i < 73; i++) begin
            rng = xorshift(rng);
            rand_pix[i] = rng[7:0] & 8'h7f;
        end
        for (i = 0; i < 32; i++) begin
            exp_set[0][i] = rand_pix[i];
            exp_set[1][i] = rand_pix[32 + i];
            exp_set[2][i] = (i < 4) ? rand_pix[68 + i] : rand_pix[i];
            exp_set[3][i] = (i == 4) ? rand_pix[72] : rand_pix[32 + i];
        end
        // Write and swap then back buffer isolation
        add_step(K_SEND, CTRL_ALIGN);
        for (i = 0; i < 32; i++) add_step(K_SEND, rand_pix[i]);
        add_step(K_SEND, CTRL_SWAP);
        add_step(K_FULL, 8'd0);
        add_step(K_SEND, CTRL_ALIGN);
        for (i = 0; i < 32; i++) add_step(K_SEND, rand_pix[32 + i]);
        add_step(K_CHECK, 8'd0);
        add_step(K_SEND, CTRL_SWAP);
        add_step(K_CHECK, 8'd1);
        // Unknown control code aligns too
        for (i = 0; i < 4; i++) add_step(K_SEND, rand_pix[64 + i]);
        add_step(K_SEND, 8'h85);
        for (i = 0; i < 4; i++) add_step(K_SEND, rand_pix[68 + i]);
        add_step(K_SEND, CTRL_SWAP);
        add_step(K_CHECK, 8'd2);
        // Partial byte dropped by cs_n so the next pixel lands at address 4
        add_step(K_CUT, 8'h3c);
        add_step(K_SEND, rand_pix[72]);
        add_step(K_SEND, CTRL_SWAP);
        add_step(K_CHECK, 8'd3);
    endtask

    // MSB first with sclk high for one clk per bit
    task automatic send_bits(input logic [7:0] data, input int nbits);
        int i;
        @(negedge clk);
        cs_n = 1'b0;
        for (i = 7; i > 7 - nbits; i--) begin
            @(negedge clk);
            sclk = 1'b0;
            mosi = data[i];
            @(negedge clk);
            sclk = 1'b1;
        end
        @(negedge clk);
        sclk = 1'b0;
        @(negedge clk);
        cs_n = 1'b1;
        repeat (30) @(negedge clk);
    endtask

    task automatic wait_vsync_fall(output bit found);
        int   cnt;
        logic prev;
        found = 1'b0;
        prev  = v_sync;
        for (cnt = 0; cnt < VSYNC_TIMEOUT && !found; cnt++) begin
            @(negedge clk);
            if (prev && !v_sync) found = 1'b1;
            prev = v_sync;
        end
    endtask

    task automatic check_colour(input string name, input logic [3:0] got,
                                input logic [3:0] exp, input int h, input int v);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s at h=%0d v=%0d: got %h expected %h", name, h, v, got, exp);
        end
    endtask

    // Cycle n of the frame shows counter pixel n/2 with colour stable on odd n
    task automatic scan_frame(input int cycles, input int set_idx);
        int         n;
        int         h;
        int         v;
        int         h_low;
        int         v_low;
        bit         found;
        logic [7:0] px;
        wait_vsync_fall(found);
        if (!found) begin
            errors++;
            timed_out = 1'b1;
            $display("No v_sync falling edge within %0d clk cycles", VSYNC_TIMEOUT);
            return;
        end
        h_low = 0;
        v_low = 0;
        for (n = 0; n < cycles; n++) begin
            if (n > 0) @(negedge clk);
            h = (n / 2) % 800;
            v = n / LINE_CLKS;
            if (!h_sync) h_low++;
            if (!v_sync) v_low++;
            if (n % LINE_CLKS == LINE_CLKS - 1) begin
                checks++;
                if (h_low != 192) begin
                    errors++;
                    $display("FAIL h_sync low clk count in line %0d: got %h expected %h",
                             v, h_low, 192);
                end
                h_low = 0;
            end
            if (n % 2 == 1) begin
                if (h < 144 || h >= 784 || v < 35 || v >= 515) begin
                    check_colour("vga_r", vga_r, 4'h0, h, v);
                    check_colour("vga_g", vga_g, 4'h0, h, v);
                    check_colour("vga_b", vga_b, 4'h0, h, v);
                end else if (v < 37 && h < 144 + 64) begin
                    px = exp_set[set_idx][(h - 144) / 2];
                    check_colour("vga_r", vga_r, widen_channel(px[5:4]), h, v);
                    check_colour("vga_g", vga_g, widen_channel(px[3:2]), h, v);
                    check_colour("vga_b", vga_b, widen_channel(px[1:0]), h, v);
                end
            end
        end
        if (cycles == FRAME_CLKS) begin
            checks++;
            if (v_low != 3200) begin
                errors++;
                $display("FAIL v_sync low clk count: got %h expected %h", v_low, 3200);
            end
            // The following frame starts right after the last cycle
            @(negedge clk);
            checks++;
            if (v_sync !== 1'b0) begin
                errors++;
                $display("FAIL v_sync at frame period end: got %h expected %h", v_sync, 1'b0);
            end
        end
    endtask

    initial begin
        int s;
        clk       = 1'b0;
        rst       = 1'b1;
        sclk      = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (s = 0; s < kind_q.size() && !timed_out; s++) begin
            case (kind_q[s])
                K_SEND:  send_bits(data_q[s], 8);
                K_CUT:   send_bits(data_q[s], 5);
                K_FULL:  scan_frame(FRAME_CLKS, data_q[s]);
                default: scan_frame(CHECK_CLKS, data_q[s]);
            endcase
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/frame_buffer.sv */
module frame_buffer
    import spi_vga_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  logic      swap_req,
    input  h_count_t  pix_x,
    input  v_count_t  pix_y,
    input  logic      active,
    input  logic      frame_start,
    output color_t    vga_r,
    output color_t    vga_g,
    output color_t    vga_b
);

    // Buffer currently written, the other one is on screen
    logic      wr_sel;
    logic      swap_pend;
    logic      active_q;
    mem_addr_t mem_col;
    mem_addr_t mem_row;
    mem_addr_t rd_addr;
    pixel_t    rd_data_0;
    pixel_t    rd_data_1;
    pixel_t    pixel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_sel    <= 1'b0;
            swap_pend <= 1'b0;
        end else if (frame_start && swap_pend) begin
            wr_sel    <= ~wr_sel;
            swap_pend <= swap_req;
        end else if (swap_req) begin
            swap_pend <= 1'b1;
        end
    end

    // Each stored pixel covers a 2x2 block of screen pixels
    assign mem_col = mem_addr_t'(pix_x / RES_DIV);
    assign mem_row = mem_addr_t'(pix_y / RES_DIV);
    assign rd_addr = mem_row * mem_addr_t'(RES_X) + mem_col;

    frame_ram u_ram_0 (
        .clk     (clk),
        .wr_en   (wr_en && !wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data_0)
    );

    frame_ram u_ram_1 (
        .clk     (clk),
        .wr_en   (wr_en && wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data_1)
    );

    assign pixel = wr_sel ? rd_data_0 : rd_data_1;

    // Aligns blanking with the read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
        end else begin
            active_q <= active;
        end
    end

    // 00RRGGBB, two bits per channel at the top of the output
    assign vga_r = active_q ? {pixel[5:4], 2'b00} : '0;
    assign vga_g = active_q ? {pixel[3:2], 2'b00} : '0;
    assign vga_b = active_q ? {pixel[1:0], 2'b00} : '0;

endmodule

/* verilog/frame_ram.sv */
module frame_ram
    import spi_vga_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  mem_addr_t rd_addr,
    output pixel_t    rd_data
);

    pixel_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one clk of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/pixel_writer.sv */
module pixel_writer
    import spi_vga_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  pixel_t    rx_byte,
    input  logic      byte_toggle,
    output logic      wr_en,
    output mem_addr_t wr_addr,
    output pixel_t    wr_data,
    output logic      swap_req
);

    logic [2:0] toggle_sync;
    logic       byte_strobe;
    logic       is_pixel;
    mem_addr_t  addr_cnt;
    mem_addr_t  addr_next;

    // Three flops across from the sclk domain, edge taken on the last two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            toggle_sync <= '0;
        end else begin
            toggle_sync <= {toggle_sync[1:0], byte_toggle};
        end
    end

    assign byte_strobe = toggle_sync[1] ^ toggle_sync[2];
    assign is_pixel    = ~rx_byte[CTRL_BIT];

    // Wrap at the end of the frame
    assign addr_next = (addr_cnt == mem_addr_t'(MEM_DEPTH - 1)) ? '0 : addr_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_cnt <= '0;
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
            if (byte_strobe) begin
                if (is_pixel) begin
                    wr_en    <= 1'b1;
                    addr_cnt <= addr_next;
                end else if (rx_byte == CTRL_SWAP) begin
                    swap_req <= 1'b1;
                end else begin
                    // CTRL_ALIGN and any unknown control code
                    addr_cnt <= '0;
                end
            end
        end
    end

    // Pixel goes to the address held before the increment
    always_ff @(posedge clk) begin
        if (byte_strobe && is_pixel) begin
            wr_addr <= addr_cnt;
            wr_data <= rx_byte;
        end
    end

endmodule

/* verilog/spi_byte_receiver.sv */
module spi_byte_receiver
    import spi_vga_pkg::*;
(
    input  logic   rst,
    input  logic   sclk,
    input  logic   cs_n,
    input  logic   mosi,
    output pixel_t rx_byte,
    output logic   byte_toggle
);

    // Only seven bits are kept, the eighth comes straight from mosi
    logic [6:0] shift_q;
    logic [2:0] bit_cnt;
    logic       last_bit;

    assign last_bit = (bit_cnt == 3'd7);

    // Deselect drops any partial byte
    always_ff @(posedge sclk or posedge rst or posedge cs_n) begin
        if (rst || cs_n) begin
            shift_q <= '0;
            bit_cnt <= '0;
        end else begin
            shift_q <= {shift_q[5:0], mosi};
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge sclk) begin
        if (last_bit) begin
            rx_byte <= {shift_q, mosi};
        end
    end

    // One flip per completed byte, a level the clk side can synchronize
    always_ff @(posedge sclk or posedge rst) begin
        if (rst) begin
            byte_toggle <= 1'b0;
        end else if (last_bit) begin
            byte_toggle <= ~byte_toggle;
        end
    end

endmodule

/* verilog/spi_vga_pkg.sv */
package spi_vga_pkg;

    // Stored frame, shown at twice the size on a 640x480 screen
    localparam int RES_X      = 320;
    localparam int RES_Y      = 240;
    localparam int RES_DIV    = 2;
    localparam int MEM_DEPTH  = RES_X * RES_Y;
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

    typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [7:0]            pixel_t;
    typedef logic [3:0]            color_t;

    // 640x480 at 60 Hz, counted in pixel periods and lines
    localparam int H_TOTAL        = 800;
    localparam int V_TOTAL        = 525;
    localparam int H_SYNC_END     = 96;
    localparam int V_SYNC_END     = 2;
    localparam int H_ACTIVE_START = 144;
    localparam int H_ACTIVE_END   = 784;
    localparam int V_ACTIVE_START = 35;
    localparam int V_ACTIVE_END   = 515;

    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;

    // System clocks per pixel period
    localparam int PIX_CLK_DIV = 2;

    // Control bytes carry the flag in bit 7
    localparam int     CTRL_BIT   = 7;
    localparam pixel_t CTRL_ALIGN = 8'h80;
    localparam pixel_t CTRL_SWAP  = 8'h81;

endpackage

/* verilog/spi_vga_top.sv */
module spi_vga_top
    import spi_vga_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   sclk,
    input  logic   cs_n,
    input  logic   mosi,
    output color_t vga_r,
    output color_t vga_g,
    output color_t vga_b,
    output logic   h_sync,
    output logic   v_sync
);

    // SPI side
    pixel_t    rx_byte;
    logic      byte_toggle;

    // Write port of the frame store
    logic      wr_en;
    mem_addr_t wr_addr;
    pixel_t    wr_data;
    logic      swap_req;

    // Scan-out position
    h_count_t  pix_x;
    v_count_t  pix_y;
    logic      active;
    logic      frame_start;

    spi_byte_receiver u_spi_rx (
        .rst         (rst),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .rx_byte     (rx_byte),
        .byte_toggle (byte_toggle)
    );

    pixel_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .byte_toggle (byte_toggle),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .swap_req    (swap_req)
    );

    frame_buffer u_frame_buf (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .swap_req    (swap_req),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .active      (active),
        .frame_start (frame_start),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

    vga_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .active      (active),
        .frame_start (frame_start)
    );

endmodule

/* verilog/vga_timing.sv */
module vga_timing
    import spi_vga_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output logic     h_sync,
    output logic     v_sync,
    output h_count_t pix_x,
    output v_count_t pix_y,
    output logic     active,
    output logic     frame_start
);

    logic [$clog2(PIX_CLK_DIV)-1:0] div_cnt;
    logic                           pix_en;
    h_count_t                       h_count;
    v_count_t                       v_count;
    logic                           h_last;
    logic                           v_last;

    // Pixel enable on the last clk of each pixel period
    assign pix_en = (div_cnt == PIX_CLK_DIV - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (pix_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign h_last = (h_count == h_count_t'(H_TOTAL - 1));
    assign v_last = (v_count == v_count_t'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (pix_en) begin
            if (h_last) begin
                h_count <= '0;
                v_count <= v_last ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // Sync pulses sit at the start of line and frame, active low
    assign h_sync = (h_count >= h_count_t'(H_SYNC_END));
    assign v_sync = (v_count >= v_count_t'(V_SYNC_END));

    assign active = (h_count >= h_count_t'(H_ACTIVE_START)) &&
                    (h_count <  h_count_t'(H_ACTIVE_END)) &&
                    (v_count >= v_count_t'(V_ACTIVE_START)) &&
                    (v_count <  v_count_t'(V_ACTIVE_END));

    // Coordinates from the active origin, zero outside it
    assign pix_x = active ? h_count - h_count_t'(H_ACTIVE_START) : '0;
    assign pix_y = active ? v_count - v_count_t'(V_ACTIVE_START) : '0;

    assign frame_start = pix_en && (h_count == '0) && (v_count == '0);

endmodule
